// ==== Makefile ====
# Verilator flow for the convolution engine

VERILATOR  ?= verilator
TOP        ?= cnn_conv_op_tb
RTL_TOP    ?= cnn_conv_op
FILELIST   ?= cnn_conv_op.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FAIL_MSG   ?= TEST FAILED
PASS_MSG   ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cnn_conv_op.f ====
rtl/conv_geom_pkg.sv
rtl/conv_data_pkg.sv
rtl/conv_scan_ctrl.sv
rtl/conv_window_fetch.sv
rtl/conv_mac_array.sv
rtl/conv_out_seq.sv
rtl/cnn_conv_op.sv
tests/cnn_conv_op_props.sv
tests/cnn_conv_op_tb.sv

// ==== rtl/cnn_conv_op.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// 3x3 convolution engine, top level
// scan control, window fetch, mac array, output sequencer
// ----------------------------------------------------------
module cnn_conv_op
  import conv_geom_pkg::*, conv_data_pkg::*;
#(
  parameter int K_C = 4  // kernel channels
) (
  input  logic                                    cnn_conv_clk,
  input  logic                                    cnn_conv_rst_n,
  input  logic                                    start,
  input  logic                                    next_ker,
  input  fmap_t                                   fmap,
  input  weight_t [K_C-1:0][KER_H-1:0][KER_W-1:0] ker,
  output sum_t    [K_C-1:0]                       top,
  output logic                                    output_valid,
  output logic                                    output_last,
  output logic [POS_BITS-1:0]                     x,
  output logic [POS_BITS-1:0]                     y,
  output logic                                    busy
);

  scan_tag_t                               tag_scan;
  scan_tag_t                               tag_fetch;
  scan_tag_t                               tag_mac;
  window_t                                 win;
  weight_t [K_C-1:0][KER_H-1:0][KER_W-1:0] ker_q;
  sum_t    [K_C-1:0]                       result;

  conv_scan_ctrl u_scan_ctrl (
    .cnn_conv_clk   (cnn_conv_clk),
    .cnn_conv_rst_n (cnn_conv_rst_n),
    .start          (start),
    .next_ker       (next_ker),
    .busy           (busy),
    .tag            (tag_scan)
  );

  conv_window_fetch #(.K_C(K_C)) u_window_fetch (
    .cnn_conv_clk   (cnn_conv_clk),
    .cnn_conv_rst_n (cnn_conv_rst_n),
    .fmap           (fmap),
    .ker            (ker),
    .tag_in         (tag_scan),
    .win            (win),
    .ker_q          (ker_q),
    .tag_out        (tag_fetch)
  );

  conv_mac_array #(.K_C(K_C)) u_mac_array (
    .cnn_conv_clk   (cnn_conv_clk),
    .cnn_conv_rst_n (cnn_conv_rst_n),
    .win            (win),
    .ker            (ker_q),
    .tag_in         (tag_fetch),
    .result         (result),
    .tag_out        (tag_mac)
  );

  conv_out_seq #(.K_C(K_C)) u_out_seq (
    .cnn_conv_clk   (cnn_conv_clk),
    .cnn_conv_rst_n (cnn_conv_rst_n),
    .result_in      (result),
    .tag            (tag_mac),
    .top            (top),
    .output_valid   (output_valid),
    .output_last    (output_last),
    .x              (x),
    .y              (y)
  );

endmodule

// ==== rtl/conv_data_pkg.sv ====
// ----------------------------------------------------------
// convolution data types
// fixed point pixels, weights, sums and the pipeline tag
// ----------------------------------------------------------
package conv_data_pkg;

  import conv_geom_pkg::*;

  localparam int PIXEL_BITS  = 8;
  localparam int WEIGHT_BITS = 8;
  localparam int SUM_BITS    = 20;  // 9 products of 16 bits, plus sign margin

  typedef logic signed [PIXEL_BITS-1:0]             pixel_t;
  typedef logic signed [WEIGHT_BITS-1:0]            weight_t;
  typedef logic signed [PIXEL_BITS+WEIGHT_BITS-1:0] prod_t;
  typedef logic signed [SUM_BITS-1:0]               sum_t;

  // whole map, element [0][0] sits in the low bits
  typedef pixel_t [FMAP_H-1:0][FMAP_W-1:0] fmap_t;

  // 3x3 neighbourhood, [i][j] is row offset i, column offset j
  typedef pixel_t [KER_H-1:0][KER_W-1:0] window_t;

  // travels alongside the data through every stage
  typedef struct packed {
    logic      valid;
    logic      last;   // final position of the final scan
    conv_pos_t pos;
  } scan_tag_t;

endpackage

// ==== rtl/conv_geom_pkg.sv ====
// ----------------------------------------------------------
// convolution geometry
// feature map, kernel and scan sizes, position word
// ----------------------------------------------------------
package conv_geom_pkg;

  // feature map and kernel size
  localparam int FMAP_H = 16;
  localparam int FMAP_W = 16;
  localparam int KER_H  = 3;
  localparam int KER_W  = 3;

  // valid positions per axis
  localparam int OUT_H = FMAP_H - KER_H + 1;
  localparam int OUT_W = FMAP_W - KER_W + 1;

  localparam int POS_BITS = 4;  // holds 0..13

  // one scan position, col is the outer loop
  typedef struct packed {
    logic [POS_BITS-1:0] col;
    logic [POS_BITS-1:0] row;
  } conv_pos_t;

  // fetch register + two mac stages
  localparam int PIPE_LAT = 3;

endpackage

// ==== rtl/conv_mac_array.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// multiply-accumulate array
// per channel: 9 products, then a small adder tree
// ----------------------------------------------------------
module conv_mac_array
  import conv_geom_pkg::*, conv_data_pkg::*;
#(
  parameter int K_C = 4
) (
  input  logic                                    cnn_conv_clk,
  input  logic                                    cnn_conv_rst_n,
  input  window_t                                 win,
  input  weight_t [K_C-1:0][KER_H-1:0][KER_W-1:0] ker,
  input  scan_tag_t                               tag_in,
  output sum_t    [K_C-1:0]                       result,
  output scan_tag_t                               tag_out
);

  prod_t [K_C-1:0][KER_H-1:0][KER_W-1:0] prod_q;   // stage one
  sum_t  [K_C-1:0][KER_H-1:0]            row_sum;
  sum_t  [K_C-1:0]                       sum_d;
  scan_tag_t                             tag_s1;

  // ----------------------------------------------------------
  // stage one: products
  // ----------------------------------------------------------
  always_ff @(posedge cnn_conv_clk) begin
    for (int c = 0; c < K_C; c++) begin
      for (int i = 0; i < KER_H; i++) begin
        for (int j = 0; j < KER_W; j++) begin
          prod_q[c][i][j] <= win[i][j] * ker[c][i][j];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // stage two: row sums, then across rows
  // ----------------------------------------------------------
  always_comb begin
    for (int c = 0; c < K_C; c++) begin
      sum_d[c] = '0;
      for (int i = 0; i < KER_H; i++) begin
        row_sum[c][i] = '0;
        for (int j = 0; j < KER_W; j++) begin
          row_sum[c][i] = row_sum[c][i] + sum_t'(prod_q[c][i][j]);  // sign extended
        end
        sum_d[c] = sum_d[c] + row_sum[c][i];
      end
    end
  end

  always_ff @(posedge cnn_conv_clk) begin
    result <= sum_d;
  end

  // tag follows the two stages
  always_ff @(posedge cnn_conv_clk) begin
    if (!cnn_conv_rst_n) begin
      tag_s1  <= '0;
      tag_out <= '0;
    end else begin
      tag_s1  <= tag_in;
      tag_out <= tag_s1;
    end
  end

endmodule

// ==== rtl/conv_out_seq.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// output sequencer
// tracks output x and y, flags valid and last per result
// ----------------------------------------------------------
module conv_out_seq
  import conv_geom_pkg::*, conv_data_pkg::*;
#(
  parameter int K_C = 4
) (
  input  logic                cnn_conv_clk,
  input  logic                cnn_conv_rst_n,
  input  sum_t    [K_C-1:0]   result_in,
  input  scan_tag_t           tag,
  output sum_t    [K_C-1:0]   top,
  output logic                output_valid,
  output logic                output_last,
  output logic [POS_BITS-1:0] x,
  output logic [POS_BITS-1:0] y
);

  localparam logic [POS_BITS-1:0] Y_LAST = POS_BITS'(OUT_H - 1);
  localparam logic [POS_BITS-1:0] X_LAST = POS_BITS'(OUT_W - 1);

  typedef enum logic {
    OUT_IDLE,
    OUT_RUN
  } out_state_t;

  out_state_t out_state;
  out_state_t out_state_nxt;

  always_comb begin
    out_state_nxt = out_state;
    case (out_state)
      OUT_IDLE: if (tag.valid && !tag.last) out_state_nxt = OUT_RUN;
      OUT_RUN:  if (!tag.valid || tag.last) out_state_nxt = OUT_IDLE;
      default:  out_state_nxt = OUT_IDLE;
    endcase
  end

  always_ff @(posedge cnn_conv_clk) begin
    if (!cnn_conv_rst_n) begin
      out_state <= OUT_IDLE;
      x         <= '0;
      y         <= '0;
    end else begin
      out_state <= out_state_nxt;
      if (tag.valid) begin
        // y inner, x outer, same order as the scan
        if (y == Y_LAST) begin
          y <= '0;
          x <= (x == X_LAST) ? '0 : x + 1'b1;
        end else begin
          y <= y + 1'b1;
        end
      end else if (out_state == OUT_IDLE) begin
        x <= '0;
        y <= '0;
      end
    end
  end

  assign top          = result_in;  // no output register
  assign output_valid = tag.valid;
  assign output_last  = tag.valid && tag.last;

endmodule

// ==== rtl/conv_scan_ctrl.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// convolution scan FSM
// walks 14x14 positions, one per cycle, then drains the pipe
// ----------------------------------------------------------
module conv_scan_ctrl
  import conv_geom_pkg::*, conv_data_pkg::*;
(
  input  logic      cnn_conv_clk,
  input  logic      cnn_conv_rst_n,
  input  logic      start,
  input  logic      next_ker,
  output logic      busy,
  output scan_tag_t tag
);

  localparam int DRAIN_BITS = $clog2(PIPE_LAT);
  localparam logic [POS_BITS-1:0] ROW_LAST = POS_BITS'(OUT_H - 1);
  localparam logic [POS_BITS-1:0] COL_LAST = POS_BITS'(OUT_W - 1);

  typedef enum logic [1:0] {
    IDLE,
    SCAN,
    DRAIN
  } scan_state_t;

  scan_state_t           state;
  scan_state_t           state_nxt;
  logic [POS_BITS-1:0]   row;        // inner loop
  logic [POS_BITS-1:0]   col;        // outer loop
  logic [DRAIN_BITS-1:0] drain_cnt;
  logic                  end_pos;
  logic                  drain_done;

  assign end_pos    = (row == ROW_LAST) && (col == COL_LAST);
  assign drain_done = (drain_cnt == DRAIN_BITS'(PIPE_LAT - 1));

  // ----------------------------------------------------------
  // state transition
  // ----------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (start) state_nxt = SCAN;
      SCAN:    if (end_pos && !next_ker) state_nxt = DRAIN;  // else wrap, new kernel
      DRAIN:   if (drain_done) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge cnn_conv_clk) begin
    if (!cnn_conv_rst_n) begin
      state     <= IDLE;
      row       <= '0;
      col       <= '0;
      drain_cnt <= '0;
    end else begin
      state <= state_nxt;
      // both counters wrap to 0 at (13,13), so idle always restarts at origin
      if (state == SCAN) begin
        if (row == ROW_LAST) begin
          row <= '0;
          col <= (col == COL_LAST) ? '0 : col + 1'b1;
        end else begin
          row <= row + 1'b1;
        end
      end
      drain_cnt <= (state == DRAIN) ? drain_cnt + 1'b1 : '0;
    end
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  assign busy      = (state != IDLE);
  assign tag.valid = (state == SCAN);
  assign tag.last  = (state == SCAN) && end_pos && !next_ker;
  assign tag.pos   = '{col: col, row: row};

endmodule

// ==== rtl/conv_window_fetch.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// window fetch
// selects the 3x3 pixels at the tag position, registers all
// ----------------------------------------------------------
module conv_window_fetch
  import conv_geom_pkg::*, conv_data_pkg::*;
#(
  parameter int K_C = 4
) (
  input  logic                                    cnn_conv_clk,
  input  logic                                    cnn_conv_rst_n,
  input  fmap_t                                   fmap,
  input  weight_t [K_C-1:0][KER_H-1:0][KER_W-1:0] ker,
  input  scan_tag_t                               tag_in,
  output window_t                                 win,
  output weight_t [K_C-1:0][KER_H-1:0][KER_W-1:0] ker_q,
  output scan_tag_t                               tag_out
);

  window_t win_d;

  // rows row..row+2, columns col..col+2
  always_comb begin
    for (int i = 0; i < KER_H; i++) begin
      for (int j = 0; j < KER_W; j++) begin
        win_d[i][j] = fmap[tag_in.pos.row + i][tag_in.pos.col + j];
      end
    end
  end

  // kernel is sampled with its window, so a kernel swap
  // between scans does not touch items already in flight
  always_ff @(posedge cnn_conv_clk) begin
    win   <= win_d;
    ker_q <= ker;
  end

  always_ff @(posedge cnn_conv_clk) begin
    if (!cnn_conv_rst_n) begin
      tag_out <= '0;
    end else begin
      tag_out <= tag_in;
    end
  end

endmodule

// ==== tests/cnn_conv_op_props.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// convolution engine protocol properties
// ----------------------------------------------------------
module cnn_conv_op_props
  import conv_geom_pkg::*;
(
  input logic                cnn_conv_clk,
  input logic                cnn_conv_rst_n,
  input logic                output_valid,
  input logic                output_last,
  input logic                busy,
  input logic [POS_BITS-1:0] x,
  input logic [POS_BITS-1:0] y
);

  a_last_with_valid: assert property (@(posedge cnn_conv_clk) disable iff (!cnn_conv_rst_n)
    output_last |-> output_valid)
    else $error("output_last without output_valid");

  a_busy_drop: assert property (@(posedge cnn_conv_clk) disable iff (!cnn_conv_rst_n)
    output_last |=> !busy)
    else $error("busy still high after output_last");

  // output coordinates stay inside 0..13
  a_xy_range: assert property (@(posedge cnn_conv_clk) disable iff (!cnn_conv_rst_n)
    (x <= POS_BITS'(OUT_W - 1)) && (y <= POS_BITS'(OUT_H - 1)))
    else $error("output coordinate out of range");

  a_valid_busy: assert property (@(posedge cnn_conv_clk) disable iff (!cnn_conv_rst_n)
    output_valid |-> busy)
    else $error("output_valid while busy is low");

endmodule

// ==== tests/cnn_conv_op_tb.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// convolution engine testbench
// directed scans checked against a 3x3 reference model
// ----------------------------------------------------------
module cnn_conv_op_tb
  import conv_geom_pkg::*, conv_data_pkg::*;
();

  localparam int K_C            = 4;
  localparam int SCAN_LEN       = OUT_H * OUT_W;  // 196 positions
  localparam int FIRST_LAT      = 1 + PIPE_LAT;
  localparam int TIMEOUT_CYCLES = 2000;  // about 1100 cycles for reset and the 5 tests

  typedef weight_t [K_C-1:0][KER_H-1:0][KER_W-1:0] ker_set_t;

  logic                cnn_conv_clk;
  logic                cnn_conv_rst_n;
  logic                start;
  logic                next_ker;
  fmap_t               fmap;
  ker_set_t            ker;
  sum_t    [K_C-1:0]   top;
  logic                output_valid;
  logic                output_last;
  logic [POS_BITS-1:0] x;
  logic [POS_BITS-1:0] y;
  logic                busy;

  fmap_t    fmap_cur;   // reference copy of the map
  ker_set_t ker_a;      // first scan kernels
  ker_set_t ker_b;      // second scan kernels
  int       err_cnt;
  int       pass_cnt;
  int       fail_cnt;
  int       cycle_cnt;

  cnn_conv_op #(.K_C(K_C)) DUT (
    .cnn_conv_clk   (cnn_conv_clk),
    .cnn_conv_rst_n (cnn_conv_rst_n),
    .start          (start),
    .next_ker       (next_ker),
    .fmap           (fmap),
    .ker            (ker),
    .top            (top),
    .output_valid   (output_valid),
    .output_last    (output_last),
    .x              (x),
    .y              (y),
    .busy           (busy)
  );

  bind cnn_conv_op cnn_conv_op_props u_props (
    .cnn_conv_clk   (cnn_conv_clk),
    .cnn_conv_rst_n (cnn_conv_rst_n),
    .output_valid   (output_valid),
    .output_last    (output_last),
    .busy           (busy),
    .x              (x),
    .y              (y)
  );

  initial begin
    cnn_conv_clk = 1'b0;
    forever #10 cnn_conv_clk = ~cnn_conv_clk;
  end

  always @(posedge cnn_conv_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // reference model and stimulus helpers
  // ----------------------------------------------------------
  function automatic int ref_sum(input fmap_t fm, input ker_set_t ks, input int c,
                                 input int xx, input int yy);
    int acc;
    acc = 0;
    for (int i = 0; i < KER_H; i++) begin
      for (int j = 0; j < KER_W; j++) begin
        acc += int'($signed(fm[yy+i][xx+j])) * int'($signed(ks[c][i][j]));
      end
    end
    return acc;
  endfunction

  function automatic fmap_t rand_fmap();
    fmap_t f;
    for (int r = 0; r < FMAP_H; r++) begin
      for (int c = 0; c < FMAP_W; c++) begin
        f[r][c] = pixel_t'($urandom);
      end
    end
    return f;
  endfunction

  function automatic ker_set_t rand_ker();
    ker_set_t k;
    for (int c = 0; c < K_C; c++) begin
      for (int i = 0; i < KER_H; i++) begin
        for (int j = 0; j < KER_W; j++) begin
          k[c][i][j] = weight_t'($urandom);
        end
      end
    end
    return k;
  endfunction

  task automatic note_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: fail, %0d errors", name, err_cnt - err_before);
    end
  endtask

  // ----------------------------------------------------------
  // output checker sampled on the falling edge
  // ----------------------------------------------------------
  task automatic check_outputs(input int n_out, input bit use_const, input int const_exp);
    int       lat;
    int       pos;
    int       exp_x;
    int       exp_y;
    int       exp_v;
    ker_set_t ks;
    lat = 0;
    do begin
      @(posedge cnn_conv_clk);
      lat++;
      @(negedge cnn_conv_clk);
      if (lat == 1 && busy !== 1'b1)
        note_error($sformatf("mismatch busy one cycle after start: got %h, expected 1", busy));
    end while (!output_valid && lat < 16);
    if (!output_valid) begin
      note_error("output_valid never rose after start");
      return;
    end
    if (lat != FIRST_LAT)
      note_error($sformatf("mismatch first output latency: got %h, expected %h",
                           lat, FIRST_LAT));
    for (int idx = 0; idx < n_out; idx++) begin
      pos   = idx % SCAN_LEN;
      exp_x = pos / OUT_H;  // y is the inner loop
      exp_y = pos % OUT_H;
      ks    = (idx < SCAN_LEN) ? ker_a : ker_b;
      if (!output_valid) begin
        note_error($sformatf("gap in output stream at output %0d", idx));
        return;
      end
      if (x !== POS_BITS'(exp_x))
        note_error($sformatf("mismatch x at output %0d: got %h, expected %h",
                             idx, x, POS_BITS'(exp_x)));
      if (y !== POS_BITS'(exp_y))
        note_error($sformatf("mismatch y at output %0d: got %h, expected %h",
                             idx, y, POS_BITS'(exp_y)));
      if (output_last !== (idx == n_out - 1))
        note_error($sformatf("mismatch output_last at output %0d: got %h, expected %h",
                             idx, output_last, (idx == n_out - 1)));
      for (int c = 0; c < K_C; c++) begin
        exp_v = use_const ? const_exp : ref_sum(fmap_cur, ks, c, exp_x, exp_y);
        if (top[c] !== sum_t'(exp_v))
          note_error($sformatf("mismatch top[%0d] at x=%0d y=%0d: got %h, expected %h",
                               c, exp_x, exp_y, top[c], sum_t'(exp_v)));
      end
      @(negedge cnn_conv_clk);
    end
    if (busy)
      note_error("busy still high one cycle after output_last");
    repeat (10) begin
      if (output_valid)
        note_error("extra output_valid after the last output");
      @(negedge cnn_conv_clk);
    end
  endtask

  // start one scan and optionally chain a second one or pulse a stray start
  task automatic run_scan(input bit b2b, input bit dup_start, input int n_out,
                          input bit use_const, input int const_exp);
    @(posedge cnn_conv_clk);
    start <= 1'b1;
    fmap  <= fmap_cur;
    ker   <= ker_a;
    fork
      begin
        for (int e = 1; e <= SCAN_LEN + 4; e++) begin
          @(posedge cnn_conv_clk);
          start    <= dup_start && (e == 60);
          next_ker <= b2b && (e == SCAN_LEN);  // high while scan sits at (13,13)
          if (b2b && e == SCAN_LEN + 1) ker <= ker_b;
        end
      end
      check_outputs(n_out, use_const, const_exp);
    join
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    if (busy !== 1'b0)
      note_error($sformatf("mismatch busy after reset: got %h, expected 0", busy));
    if (output_valid !== 1'b0)
      note_error($sformatf("mismatch output_valid after reset: got %h, expected 0", output_valid));
    if (output_last !== 1'b0)
      note_error($sformatf("mismatch output_last after reset: got %h, expected 0", output_last));
    if (x !== '0)
      note_error($sformatf("mismatch x after reset: got %h, expected 0", x));
    if (y !== '0)
      note_error($sformatf("mismatch y after reset: got %h, expected 0", y));
    finish_test("test 1 reset values", e0);
  endtask

  task automatic test_single_scan();
    int e0;
    e0       = err_cnt;
    fmap_cur = rand_fmap();
    ker_a    = rand_ker();
    run_scan(1'b0, 1'b0, SCAN_LEN, 1'b0, 0);
    finish_test("test 2 single scan", e0);
  endtask

  task automatic test_back_to_back();
    int e0;
    e0       = err_cnt;
    fmap_cur = rand_fmap();
    ker_a    = rand_ker();
    ker_b    = rand_ker();
    run_scan(1'b1, 1'b0, 2 * SCAN_LEN, 1'b0, 0);
    finish_test("test 3 back-to-back scans", e0);
  endtask

  task automatic test_start_while_busy();
    int e0;
    e0       = err_cnt;
    fmap_cur = rand_fmap();
    ker_a    = rand_ker();
    run_scan(1'b0, 1'b1, SCAN_LEN, 1'b0, 0);
    finish_test("test 4 start while busy", e0);
  endtask

  task automatic test_extreme_values();
    int e0;
    e0 = err_cnt;
    for (int r = 0; r < FMAP_H; r++) begin
      for (int c = 0; c < FMAP_W; c++) begin
        fmap_cur[r][c] = pixel_t'(-128);
      end
    end
    for (int c = 0; c < K_C; c++) begin
      for (int i = 0; i < KER_H; i++) begin
        for (int j = 0; j < KER_W; j++) begin
          ker_a[c][i][j] = weight_t'(-128);
        end
      end
    end
    run_scan(1'b0, 1'b0, SCAN_LEN, 1'b1, 9 * 128 * 128);  // 147456
    finish_test("test 5 extreme values", e0);
  endtask

  initial begin
    void'($urandom(70589));
    err_cnt        = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    cycle_cnt      = 0;
    cnn_conv_rst_n = 1'b0;
    start          = 1'b0;
    next_ker       = 1'b0;
    fmap           = '0;
    ker            = '0;
    fmap_cur       = '0;
    ker_a          = '0;
    ker_b          = '0;
    repeat (4) @(posedge cnn_conv_clk);
    cnn_conv_rst_n <= 1'b1;
    @(negedge cnn_conv_clk);
    test_reset();
    test_single_scan();
    test_back_to_back();
    test_start_while_busy();
    test_extreme_values();
    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
